// ==== pipe_tests.txt ====
# Columns: instr kind index value, all hex; kind 0 reg, 1 store, 2 branch, 3 does not retire
# "T name" starts a test; registers and data memory carry over from test to test
T alu_r0
61000005 0 1 00000005  addi r1, r0, 5
6200FFFD 0 2 FFFFFFFD  addi r2, r0, -3
13120000 0 3 00000002  add  r3, r1, r2
24120000 0 4 00000008  sub  r4, r1, r2
35120000 0 5 00000005  and  r5, r1, r2
46120000 0 6 FFFFFFFD  or   r6, r1, r2
57210000 0 7 00000001  slt  r7, r2, r1
58120000 0 8 00000000  slt  r8, r1, r2
60100007 0 0 0000000C  addi r0, r1, 7
19010000 0 9 00000005  add  r9, r0, r1
T forward_chain
6A000010 0 A 00000010  addi r10, r0, 0x10
1BAA0000 0 B 00000020  add  r11, r10, r10
2CBA0000 0 C 00000010  sub  r12, r11, r10
1DBC0000 0 D 00000030  add  r13, r11, r12
4ADB0000 0 A 00000030  or   r10, r13, r11
T load_use
6E000008 0 E 00000008  addi r14, r0, 8
80EA0004 1 3 00000030  sw   r10, 4(r14)
7FE00004 0 F 00000030  lw   r15, 4(r14)
11FF0000 0 1 00000060  add  r1, r15, r15
221F0000 0 2 00000030  sub  r2, r1, r15
T store_load
8006003C 1 F FFFFFFFD  sw   r6, 0x3c(r0)
7500003C 0 5 FFFFFFFD  lw   r5, 0x3c(r0)
80070040 1 0 00000001  sw   r7, 0x40(r0)
78000000 0 8 00000001  lw   r8, 0(r0)
T branch
90110000 2 0 00000001  beq  r1, r1
69000077 3 0 00000000  addi r9, r0, 0x77
69000055 0 9 00000055  addi r9, r0, 0x55
90900000 2 0 00000000  beq  r9, r0
64900001 0 4 00000056  addi r4, r9, 1
90440000 2 0 00000001  beq  r4, r4
80040000 3 0 00000000  sw   r4, 0(r0)
76000000 0 6 00000001  lw   r6, 0(r0)

// ==== sources.f ====
cpu_pkg.sv
reg_file.sv
instr_decode.sv
hazard_bubble.sv
alu_execute.sv
mem_result.sv
cpu_pipe_top.sv
tb_cpu_pipe.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu_pipe -f sources.f

# Exit status is nonzero when the testbench stops on $fatal
./obj_dir/Vtb_cpu_pipe

// ==== tb_cpu_pipe.sv ====
`default_nettype none

module tb_cpu_pipe;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT  = 200;
    localparam int IDLE_CYCLES = 12;

    logic                       clk;
    logic                       rst_n;
    logic                       instr_req;
    logic                       instr_ack;
    logic [cpu_pkg::DATA_W-1:0] instr;
    logic                       retire_req;
    logic                       retire_ack;
    cpu_pkg::retire_t           retire;

    // Program and expected retire records, in order
    logic [cpu_pkg::DATA_W-1:0] instr_q [$];
    cpu_pkg::retire_t           exp_q [$];
    string                      exp_name_q [$];
    integer                     seed;

    cpu_pipe_top u_cpu_pipe_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_req  (instr_req),
        .instr_ack  (instr_ack),
        .instr      (instr),
        .retire_req (retire_req),
        .retire_ack (retire_ack),
        .retire     (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Failure and compare
    //////////////////////////////////////////////////
    task automatic fail_and_stop(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test_name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            fail_and_stop($sformatf("[FAIL] %s %s: expected %h, actual %h",
                                    test_name, field, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////
    // Test file
    //////////////////////////////////////////////////
    task automatic load_tests();
        int               fd;
        int               last;
        int               n;
        string            line;
        string            cur_name;
        logic [31:0]      word;
        logic [31:0]      kind_v;
        logic [31:0]      idx_v;
        logic [31:0]      val_v;
        cpu_pkg::retire_t rec;

        cur_name = "unnamed";
        fd = $fopen("pipe_tests.txt", "r");
        if (fd == 0) begin
            fail_and_stop("Could not open pipe_tests.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            // Test name line
            if (line[0] == "T") begin
                last = line.len() - 1;
                if (line[last] == 8'h0a) begin
                    last = last - 1;
                end
                cur_name = line.substr(2, last);
                continue;
            end
            n = $sscanf(line, "%h %h %h %h", word, kind_v, idx_v, val_v);
            if (n != 4 || kind_v > 3) begin
                fail_and_stop({"Malformed line in pipe_tests.txt: ", line});
            end
            instr_q.push_back(word);
            // Kind 3 is an instruction that must not retire
            if (kind_v != 3) begin
                rec.kind  = cpu_pkg::ret_kind_e'(kind_v[1:0]);
                rec.index = idx_v[3:0];
                rec.value = val_v;
                exp_q.push_back(rec);
                exp_name_q.push_back(cur_name);
            end
        end
        $fclose(fd);
        if (exp_q.size() == 0) begin
            fail_and_stop("No expected retire records found in pipe_tests.txt");
        end
    endtask

    //////////////////////////////////////////////////
    // Instruction sender
    //////////////////////////////////////////////////
    task automatic send_instr(input logic [31:0] word);
        int waited;

        instr     = word;
        instr_req = 1'b1;
        waited    = 0;
        while (!instr_ack) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_and_stop("Timeout waiting for instr_ack to rise");
            end
        end
        instr_req = 1'b0;
        waited    = 0;
        while (instr_ack) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_and_stop("Timeout waiting for instr_ack to fall");
            end
        end
    endtask

    task automatic send_all();
        foreach (instr_q[i]) begin
            send_instr(instr_q[i]);
        end
    endtask

    //////////////////////////////////////////////////
    // Retire receiver
    //////////////////////////////////////////////////
    task automatic take_retire(output cpu_pkg::retire_t rec);
        int waited;
        int delay;

        waited = 0;
        while (!retire_req) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_and_stop("Timeout waiting for retire_req to rise");
            end
        end
        rec = retire;
        // Random back-pressure before the ack
        delay = $unsigned($random(seed)) % 4;
        for (int d = 0; d < delay; d++) begin
            @(posedge clk);
            #2;
        end
        retire_ack = 1'b1;
        waited     = 0;
        while (retire_req) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_and_stop("Timeout waiting for retire_req to fall");
            end
        end
        retire_ack = 1'b0;
    endtask

    task automatic check_all();
        cpu_pkg::retire_t rec;

        foreach (exp_q[i]) begin
            take_retire(rec);
            check_value(exp_name_q[i], "kind", 32'(exp_q[i].kind), 32'(rec.kind));
            check_value(exp_name_q[i], "index", 32'(exp_q[i].index), 32'(rec.index));
            check_value(exp_name_q[i], "value", exp_q[i].value, rec.value);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        rst_n      = 1'b0;
        instr_req  = 1'b0;
        instr      = '0;
        retire_ack = 1'b0;
        seed       = 41;
        load_tests();
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        fork
            send_all();
            check_all();
        join
        // Squashed words must stay silent
        for (int c = 0; c < IDLE_CYCLES; c++) begin
            @(posedge clk);
            #2;
            if (retire_req) begin
                fail_and_stop("A record retired after the last expected one");
            end
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_pipe_top.sv ====
`default_nettype none

module cpu_pipe_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       instr_req,
    output logic                            instr_ack,
    input  wire logic [cpu_pkg::DATA_W-1:0] instr,
    output logic                            retire_req,
    input  wire logic                       retire_ack,
    output cpu_pkg::retire_t                retire
);

    logic [cpu_pkg::REG_AW-1:0] rs_addr;
    logic [cpu_pkg::REG_AW-1:0] rt_addr;
    logic [cpu_pkg::DATA_W-1:0] rs_data;
    logic [cpu_pkg::DATA_W-1:0] rt_data;
    logic                       wr_en;
    logic [cpu_pkg::REG_AW-1:0] wr_addr;
    logic [cpu_pkg::DATA_W-1:0] wr_data;
    cpu_pkg::dec_ex_t           dec;
    logic                       dec_valid;
    cpu_pkg::dec_ex_t           gated;
    logic                       gated_valid;
    logic                       haz_stall;
    logic                       hold;
    logic                       dec_stall;
    cpu_pkg::ex_res_t           ex;
    logic                       ex_valid;
    logic                       branch_taken;

    // Decode freezes on either source
    assign dec_stall = haz_stall || hold;

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    instr_decode u_instr_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr_req (instr_req),
        .instr_ack (instr_ack),
        .instr     (instr),
        .stall     (dec_stall),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .dec       (dec),
        .dec_valid (dec_valid)
    );

    hazard_bubble u_hazard_bubble (
        .dec          (dec),
        .dec_valid    (dec_valid),
        .ex_ctrl      (ex.ctrl),
        .ex_rd        (ex.rd),
        .ex_valid     (ex_valid),
        .branch_taken (branch_taken),
        .gated        (gated),
        .gated_valid  (gated_valid),
        .stall        (haz_stall)
    );

    alu_execute u_alu_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .hold         (hold),
        .gated        (gated),
        .gated_valid  (gated_valid),
        .dec_valid    (dec_valid),
        .fwd_en       (wr_en),
        .fwd_rd       (wr_addr),
        .fwd_val      (wr_data),
        .ex           (ex),
        .ex_valid     (ex_valid),
        .branch_taken (branch_taken)
    );

    mem_result u_mem_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex         (ex),
        .ex_valid   (ex_valid),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .hold       (hold),
        .retire_req (retire_req),
        .retire_ack (retire_ack),
        .retire     (retire)
    );

endmodule

`default_nettype wire

// ==== mem_result.sv ====
`default_nettype none

module mem_result (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire cpu_pkg::ex_res_t           ex,
    input  wire logic                       ex_valid,
    output logic                            wr_en,
    output logic      [cpu_pkg::REG_AW-1:0] wr_addr,
    output logic      [cpu_pkg::DATA_W-1:0] wr_data,
    output logic                            hold,
    output logic                            retire_req,
    input  wire logic                       retire_ack,
    output cpu_pkg::retire_t                retire
);

    logic [cpu_pkg::DATA_W-1:0] dmem [cpu_pkg::MEM_WORDS];
    logic [cpu_pkg::MEM_AW-1:0] word_idx;
    logic                       capture;
    logic                       retires;
    cpu_pkg::retire_t           rec_next;

    //////////////////////////////////////////////////
    // Data memory and writeback
    //////////////////////////////////////////////////
    assign word_idx = ex.alu_val[5:2];
    assign capture  = ex_valid && !hold;

    always_ff @(posedge clk) begin
        if (capture && ex.ctrl.mem_write) begin
            dmem[word_idx] <= ex.store_val;
        end
    end

    assign wr_en   = capture && ex.ctrl.reg_write;
    assign wr_addr = ex.rd;
    assign wr_data = ex.ctrl.mem_read ? dmem[word_idx] : ex.alu_val;

    //////////////////////////////////////////////////
    // Retire record
    //////////////////////////////////////////////////
    assign retires = ex.ctrl.reg_write || ex.ctrl.mem_write || ex.ctrl.branch;

    always_comb begin
        rec_next = '0;
        if (ex.ctrl.mem_write) begin
            rec_next.kind  = cpu_pkg::RET_STORE;
            rec_next.index = word_idx;
            rec_next.value = ex.store_val;
        end else if (ex.ctrl.branch) begin
            rec_next.kind  = cpu_pkg::RET_BRANCH;
            rec_next.value = ex.alu_val;
        end else begin
            rec_next.kind  = cpu_pkg::RET_REG;
            rec_next.index = ex.rd;
            rec_next.value = wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_req <= 1'b0;
        end else if (capture && retires) begin
            retire_req <= 1'b1;
        end else if (retire_ack) begin
            retire_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture && retires) begin
            retire <= rec_next;
        end
    end

    // Open until the receiver drops ack
    assign hold = retire_req || retire_ack;

    retire_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_req && !retire_ack) |=> $stable(retire))
        else $error("retire record moved during handshake");

endmodule

`default_nettype wire

// ==== alu_execute.sv ====
`default_nettype none

module alu_execute (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       hold,
    input  wire cpu_pkg::dec_ex_t           gated,
    input  wire logic                       gated_valid,
    input  wire logic                       dec_valid,
    input  wire logic                       fwd_en,
    input  wire logic [cpu_pkg::REG_AW-1:0] fwd_rd,
    input  wire logic [cpu_pkg::DATA_W-1:0] fwd_val,
    output cpu_pkg::ex_res_t                ex,
    output logic                            ex_valid,
    output logic                            branch_taken
);

    logic [cpu_pkg::DATA_W-1:0] op_a;
    logic [cpu_pkg::DATA_W-1:0] op_b;
    logic [cpu_pkg::DATA_W-1:0] rt_fwd;
    logic [cpu_pkg::DATA_W-1:0] alu_out;
    logic                       own_ok;
    logic                       squash_pend;
    cpu_pkg::ex_res_t           ex_next;

    //////////////////////////////////////////////////
    // Forwarding
    //////////////////////////////////////////////////
    // Load data is not ready here and the hazard unit stalls that case
    assign own_ok = ex_valid && ex.ctrl.reg_write && !ex.ctrl.mem_read && (ex.rd != '0);

    always_comb begin
        if (own_ok && (ex.rd == gated.rs)) begin
            op_a = ex.alu_val;
        end else if (fwd_en && (fwd_rd != '0) && (fwd_rd == gated.rs)) begin
            op_a = fwd_val;
        end else begin
            op_a = gated.rs_val;
        end
        if (own_ok && (ex.rd == gated.rt)) begin
            rt_fwd = ex.alu_val;
        end else if (fwd_en && (fwd_rd != '0) && (fwd_rd == gated.rt)) begin
            rt_fwd = fwd_val;
        end else begin
            rt_fwd = gated.rt_val;
        end
    end

    assign op_b = gated.ctrl.alu_src ? gated.imm : rt_fwd;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////
    always_comb begin
        case (gated.ctrl.alu_op)
            cpu_pkg::ALU_SUB: alu_out = op_a - op_b;
            cpu_pkg::ALU_AND: alu_out = op_a & op_b;
            cpu_pkg::ALU_OR:  alu_out = op_a | op_b;
            cpu_pkg::ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            default:          alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        ex_next           = '0;
        ex_next.ctrl      = gated_valid ? gated.ctrl : '0;
        ex_next.rd        = gated.rd;
        ex_next.store_val = rt_fwd;
        // Branch result travels as 1 or 0
        ex_next.alu_val   = gated.ctrl.branch ? {31'd0, op_a == rt_fwd} : alu_out;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex.ctrl     <= '0;
            ex_valid    <= 1'b0;
            squash_pend <= 1'b0;
        end else if (!hold) begin
            ex.ctrl  <= ex_next.ctrl;
            ex_valid <= gated_valid;
            if (gated_valid && gated.ctrl.branch && ex_next.alu_val[0]) begin
                squash_pend <= 1'b1;
            end else if (dec_valid) begin
                // The word in decode was dropped this cycle
                squash_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            ex.rd        <= ex_next.rd;
            ex.alu_val   <= ex_next.alu_val;
            ex.store_val <= ex_next.store_val;
        end
    end

    // Stays up until one following word has been squashed
    assign branch_taken = squash_pend;

    // Word behind a taken branch never enters the register
    squash_once: assert property (@(posedge clk) disable iff (!rst_n)
        (branch_taken && !hold) |=> !ex_valid)
        else $error("word entered execute behind a taken branch");

endmodule

`default_nettype wire

// ==== hazard_bubble.sv ====
`default_nettype none

module hazard_bubble (
    input  wire cpu_pkg::dec_ex_t           dec,
    input  wire logic                       dec_valid,
    input  wire cpu_pkg::ctrl_t             ex_ctrl,
    input  wire logic [cpu_pkg::REG_AW-1:0] ex_rd,
    input  wire logic                       ex_valid,
    input  wire logic                       branch_taken,
    output cpu_pkg::dec_ex_t                gated,
    output logic                            gated_valid,
    output logic                            stall
);

    logic rs_hit;
    logic rt_hit;

    // Load in execute feeding the word in decode
    assign rs_hit = (dec.rs != '0) && (dec.rs == ex_rd);
    assign rt_hit = (dec.rt != '0) && (dec.rt == ex_rd);

    assign stall = dec_valid && ex_valid && ex_ctrl.mem_read && (rs_hit || rt_hit);

    always_comb begin
        gated = dec;
        if (stall || branch_taken) begin
            gated.ctrl = '0;
        end
    end

    // A taken branch kills the word; a stall keeps it in decode
    assign gated_valid = dec_valid && !stall && !branch_taken;

    // Bubble that reached the execute register
    always_comb begin
        if (!ex_valid) begin
            bubble_quiet: assert #0 (!ex_ctrl.reg_write && !ex_ctrl.mem_write)
                else $error("bubble carries a write");
        end
    end

endmodule

`default_nettype wire

// ==== instr_decode.sv ====
`default_nettype none

module instr_decode (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       instr_req,
    output logic                            instr_ack,
    input  wire logic [cpu_pkg::DATA_W-1:0] instr,
    input  wire logic                       stall,
    input  wire logic [cpu_pkg::DATA_W-1:0] rs_data,
    input  wire logic [cpu_pkg::DATA_W-1:0] rt_data,
    output logic      [cpu_pkg::REG_AW-1:0] rs_addr,
    output logic      [cpu_pkg::REG_AW-1:0] rt_addr,
    output cpu_pkg::dec_ex_t                dec,
    output logic                            dec_valid
);

    logic [cpu_pkg::DATA_W-1:0] word;
    logic                       accept;
    cpu_pkg::opcode_e           opcode;
    cpu_pkg::ctrl_t             ctrl;

    //////////////////////////////////////////////////
    // Four-phase receive
    //////////////////////////////////////////////////
    // New word only once the previous ack has fallen
    assign accept = instr_req && !instr_ack && !stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_ack <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            if (accept) begin
                instr_ack <= 1'b1;
            end else if (!instr_req) begin
                instr_ack <= 1'b0;
            end
            if (!stall) begin
                dec_valid <= accept;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word <= instr;
        end
    end

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////
    assign opcode = cpu_pkg::opcode_e'(word[31:28]);

    always_comb begin
        ctrl = '0;
        case (opcode)
            cpu_pkg::OP_ADD:  ctrl.reg_write = 1'b1;
            cpu_pkg::OP_SUB: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = cpu_pkg::ALU_SUB;
            end
            cpu_pkg::OP_AND: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = cpu_pkg::ALU_AND;
            end
            cpu_pkg::OP_OR: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = cpu_pkg::ALU_OR;
            end
            cpu_pkg::OP_SLT: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = cpu_pkg::ALU_SLT;
            end
            cpu_pkg::OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            cpu_pkg::OP_LW: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            // Compare happens in execute on rs and rt
            cpu_pkg::OP_BEQ:  ctrl.branch = 1'b1;
            default:          ctrl = '0;
        endcase
    end

    assign rs_addr = word[23:20];
    assign rt_addr = word[19:16];

    always_comb begin
        dec        = '0;
        dec.ctrl   = ctrl;
        dec.rd     = word[27:24];
        dec.rs     = rs_addr;
        dec.rt     = rt_addr;
        dec.rs_val = rs_data;
        dec.rt_val = rt_data;
        dec.imm    = {{(cpu_pkg::DATA_W - cpu_pkg::IMM_W){word[15]}}, word[15:0]};
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none

module reg_file (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [cpu_pkg::REG_AW-1:0] rs_addr,
    input  wire logic [cpu_pkg::REG_AW-1:0] rt_addr,
    output logic      [cpu_pkg::DATA_W-1:0] rs_data,
    output logic      [cpu_pkg::DATA_W-1:0] rt_data,
    input  wire logic                       wr_en,
    input  wire logic [cpu_pkg::REG_AW-1:0] wr_addr,
    input  wire logic [cpu_pkg::DATA_W-1:0] wr_data
);

    logic [cpu_pkg::DATA_W-1:0] regs [cpu_pkg::REG_N];
    logic                       wr_live;

    // r0 never takes a write
    assign wr_live = wr_en && (wr_addr != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_pkg::REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle write shows on the read ports
    assign rs_data = (wr_live && (wr_addr == rs_addr)) ? wr_data : regs[rs_addr];
    assign rt_data = (wr_live && (wr_addr == rt_addr)) ? wr_data : regs[rt_addr];

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////
    localparam int DATA_W    = 32;
    localparam int REG_N     = 16;
    localparam int REG_AW    = 4;
    localparam int MEM_WORDS = 16;
    localparam int MEM_AW    = 4;
    localparam int IMM_W     = 16;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////
    // Opcode sits in instruction bits 31..28
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_SLT  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LW   = 4'd7,
        OP_SW   = 4'd8,
        OP_BEQ  = 4'd9
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    typedef enum logic [1:0] {
        RET_REG    = 2'd0,
        RET_STORE  = 2'd1,
        RET_BRANCH = 2'd2
    } ret_kind_e;

    //////////////////////////////////////////////////
    // Stage records
    //////////////////////////////////////////////////
    // All zero means bubble
    typedef struct packed {
        logic    alu_src;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t               ctrl;
        logic [REG_AW-1:0]   rd;
        logic [REG_AW-1:0]   rs;
        logic [REG_AW-1:0]   rt;
        logic [DATA_W-1:0]   rs_val;
        logic [DATA_W-1:0]   rt_val;
        logic [DATA_W-1:0]   imm;
    } dec_ex_t;

    typedef struct packed {
        ctrl_t               ctrl;
        logic [REG_AW-1:0]   rd;
        logic [DATA_W-1:0]   alu_val;
        logic [DATA_W-1:0]   store_val;
    } ex_res_t;

    typedef struct packed {
        ret_kind_e           kind;
        logic [REG_AW-1:0]   index;
        logic [DATA_W-1:0]   value;
    } retire_t;

endpackage

`default_nettype wire
